// ==== rtl/udp_echo_pkg.sv ====
/* UDP echo shared types and constants */

package udp_echo_pkg;

    // IPv4 address, first octet in the top byte
    typedef logic [31:0] ip_addr_t;

    typedef logic [15:0] udp_port_t;

    // Decoded UDP header, used for both received frames and replies
    typedef struct packed {
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [15:0] checksum;
    } udp_hdr_t;

    // One payload byte with its framing flags
    typedef struct packed {
        logic [7:0] data;
        // Set on the final byte of the frame
        logic       last;
        // Error flag from the receive side, carried through unchanged
        logic       user;
    } payload_beat_t;

    // Source address of every reply, 192.168.1.128
    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Destination port that gets answered
    localparam udp_port_t ECHO_PORT = 16'd1234;

    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Reply headers waiting for transmit
    localparam int HDR_FIFO_DEPTH = 4;

    // Payload bytes buffered behind the reply headers
    localparam int PAYLOAD_FIFO_DEPTH = 64;

endpackage

// ==== rtl/stream_fifo.sv ====
/* Valid/ready stream FIFO */

`timescale 1ns/100ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clk_125mhz,
    input  logic     rst_125mhz,

    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // Entries held in mem, the output register not included
    logic [CNT_W-1:0] count;

    logic load_out;
    logic mem_empty;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign mem_empty = (count == '0);

    // Output register is free or being emptied this cycle
    assign load_out = !out_valid || out_ready;
    assign mem_rd   = load_out && !mem_empty;
    // Empty FIFO sends the input straight to the output register
    assign bypass   = load_out && mem_empty && in_valid;
    assign mem_wr   = in_valid && in_ready && !bypass;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (mem_wr && !mem_rd) begin
                count <= count + 1'b1;
            end else if (mem_rd && !mem_wr) begin
                count <= count - 1'b1;
            end
            if (load_out) begin
                out_valid <= mem_rd || bypass;
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (mem_wr) begin
            mem[wr_ptr] <= in_data;
        end
        if (mem_rd) begin
            out_data <= mem[rd_ptr];
        end else if (bypass) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== rtl/udp_port_filter.sv ====
/* UDP destination port filter */

`timescale 1ns/100ps

module udp_port_filter
    import udp_echo_pkg::*;
(
    input  logic          clk_125mhz,
    input  logic          rst_125mhz,

    // Received frame
    input  udp_hdr_t      rx_hdr,
    input  logic          rx_hdr_valid,
    output logic          rx_hdr_ready,
    input  payload_beat_t rx_payload,
    input  logic          rx_payload_valid,
    output logic          rx_payload_ready,

    // Reply header towards the header FIFO
    output udp_hdr_t      reply_hdr,
    output logic          reply_hdr_valid,
    input  logic          hdr_fifo_ready,

    // Echoed payload towards the payload FIFO
    output payload_beat_t fwd_payload,
    output logic          fwd_payload_valid,
    input  logic          payload_fifo_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FORWARD,
        ST_DISCARD
    } state_t;

    state_t state;

    // Low for the first cycle out of reset
    logic running;

    logic hdr_match;
    logic hdr_xfer;
    logic payload_xfer;

    assign hdr_match = (rx_hdr.dst_port == ECHO_PORT);

    // Echoed headers need room for the reply, others are always taken
    always_comb begin
        rx_hdr_ready = 1'b0;
        if (running && state == ST_IDLE) begin
            if (hdr_match) begin
                rx_hdr_ready = hdr_fifo_ready && !reply_hdr_valid;
            end else begin
                rx_hdr_ready = 1'b1;
            end
        end
    end

    // Payload steering follows the decision made on the header
    always_comb begin
        case (state)
            ST_FORWARD: rx_payload_ready = payload_fifo_ready;
            ST_DISCARD: rx_payload_ready = 1'b1;
            default:    rx_payload_ready = 1'b0;
        endcase
    end

    assign fwd_payload       = rx_payload;
    assign fwd_payload_valid = (state == ST_FORWARD) && rx_payload_valid;

    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;
    assign payload_xfer = rx_payload_valid && rx_payload_ready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state   <= ST_IDLE;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= hdr_match ? ST_FORWARD : ST_DISCARD;
                    end
                end
                ST_FORWARD, ST_DISCARD: begin
                    // Frame ends on the transferred last beat
                    if (payload_xfer && rx_payload.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // The FIFO had room at accept time and only this block writes it,
    // so the registered reply always goes in on the following cycle
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            reply_hdr_valid <= 1'b0;
        end else if (hdr_xfer && hdr_match) begin
            reply_hdr_valid <= 1'b1;
        end else if (hdr_fifo_ready) begin
            reply_hdr_valid <= 1'b0;
        end
    end

    // Swap both ends of the flow and answer from the local address
    always_ff @(posedge clk_125mhz) begin
        if (hdr_xfer && hdr_match) begin
            reply_hdr.src_ip   <= LOCAL_IP;
            reply_hdr.dst_ip   <= rx_hdr.src_ip;
            reply_hdr.src_port <= rx_hdr.dst_port;
            reply_hdr.dst_port <= rx_hdr.src_port;
            reply_hdr.length   <= rx_hdr.length;
            reply_hdr.ttl      <= REPLY_TTL;
            // No checksum on replies
            reply_hdr.checksum <= 16'd0;
        end
    end

endmodule

// ==== rtl/payload_led_capture.sv ====
/* First payload byte to LEDs */

`timescale 1ns/100ps

module payload_led_capture
    import udp_echo_pkg::*;
(
    input  logic          clk_125mhz,
    input  logic          rst_125mhz,

    // Monitored stream, observed only
    input  payload_beat_t beat,
    input  logic          beat_valid,
    input  logic          beat_ready,

    output logic [7:0]    led
);

    // Next transferred beat opens a new frame
    logic frame_start;
    logic beat_xfer;

    assign beat_xfer = beat_valid && beat_ready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            frame_start <= 1'b1;
            led         <= 8'd0;
        end else if (beat_xfer) begin
            if (frame_start) begin
                led <= beat.data;
            end
            // Single-beat frames keep the flag set
            frame_start <= beat.last;
        end
    end

endmodule

// ==== rtl/udp_echo_top.sv ====
/* UDP echo engine top level */

`timescale 1ns/100ps

module udp_echo_top
    import udp_echo_pkg::*;
(
    input  logic          clk_125mhz,
    input  logic          rst_125mhz,

    // Received UDP frames
    input  udp_hdr_t      rx_hdr,
    input  logic          rx_hdr_valid,
    output logic          rx_hdr_ready,
    input  payload_beat_t rx_payload,
    input  logic          rx_payload_valid,
    output logic          rx_payload_ready,

    // Echo replies
    output udp_hdr_t      tx_hdr,
    output logic          tx_hdr_valid,
    input  logic          tx_hdr_ready,
    output payload_beat_t tx_payload,
    output logic          tx_payload_valid,
    input  logic          tx_payload_ready,

    output logic [7:0]    led
);

    // Filter to header FIFO
    udp_hdr_t      reply_hdr;
    logic          reply_hdr_valid;
    logic          hdr_fifo_ready;

    // Filter to payload FIFO
    payload_beat_t fwd_payload;
    logic          fwd_payload_valid;
    logic          payload_fifo_ready;

    udp_port_filter filter_inst (
        .clk_125mhz         (clk_125mhz),
        .rst_125mhz         (rst_125mhz),
        .rx_hdr             (rx_hdr),
        .rx_hdr_valid       (rx_hdr_valid),
        .rx_hdr_ready       (rx_hdr_ready),
        .rx_payload         (rx_payload),
        .rx_payload_valid   (rx_payload_valid),
        .rx_payload_ready   (rx_payload_ready),
        .reply_hdr          (reply_hdr),
        .reply_hdr_valid    (reply_hdr_valid),
        .hdr_fifo_ready     (hdr_fifo_ready),
        .fwd_payload        (fwd_payload),
        .fwd_payload_valid  (fwd_payload_valid),
        .payload_fifo_ready (payload_fifo_ready)
    );

    stream_fifo #(
        .payload_t (udp_hdr_t),
        .DEPTH     (HDR_FIFO_DEPTH)
    ) hdr_fifo_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .in_data    (reply_hdr),
        .in_valid   (reply_hdr_valid),
        .in_ready   (hdr_fifo_ready),
        .out_data   (tx_hdr),
        .out_valid  (tx_hdr_valid),
        .out_ready  (tx_hdr_ready)
    );

    stream_fifo #(
        .payload_t (payload_beat_t),
        .DEPTH     (PAYLOAD_FIFO_DEPTH)
    ) payload_fifo_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .in_data    (fwd_payload),
        .in_valid   (fwd_payload_valid),
        .in_ready   (payload_fifo_ready),
        .out_data   (tx_payload),
        .out_valid  (tx_payload_valid),
        .out_ready  (tx_payload_ready)
    );

    // Watches the transmit side, so the LEDs follow echoed frames only
    payload_led_capture led_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .beat       (tx_payload),
        .beat_valid (tx_payload_valid),
        .beat_ready (tx_payload_ready),
        .led        (led)
    );

endmodule

// ==== tb/udp_echo_cases.svh ====
/* UDP echo test frames */

`ifndef UDP_ECHO_CASES_SVH
`define UDP_ECHO_CASES_SVH

// UDP header bytes counted in the length field
localparam int UDP_HDR_BYTES = 8;

// One received frame, the payload bytes themselves are random
typedef struct packed {
    ip_addr_t   src_ip;
    ip_addr_t   dst_ip;
    udp_port_t  src_port;
    udp_port_t  dst_port;
    logic [7:0] ttl;
    logic [7:0] payload_len;
    // User flag carried on the last beat
    logic       last_user;
} frame_case_t;

localparam int NUM_CASES = 10;

// Source IP, destination IP, source port, destination port, TTL, length, user
localparam frame_case_t FRAME_CASES [NUM_CASES] = '{
    '{32'hC0A8_0105, LOCAL_IP,        16'd5000,  ECHO_PORT, 8'd64,  8'd1,  1'b0},
    '{32'h0A00_0007, LOCAL_IP,        16'd40000, 16'd1235,  8'd128, 8'd12, 1'b0},
    '{32'hC0A8_0114, LOCAL_IP,        ECHO_PORT, ECHO_PORT, 8'd1,   8'd40, 1'b0},
    '{32'hAC10_0309, LOCAL_IP,        16'd53,    16'd53,    8'd64,  8'd8,  1'b1},
    '{32'hC0A8_0121, LOCAL_IP,        16'd61000, ECHO_PORT, 8'd255, 8'd17, 1'b1},
    // Byte-swapped echo port must not match
    '{32'hC0A8_0105, LOCAL_IP,        16'd5000,  16'hD204,  8'd64,  8'd3,  1'b0},
    '{32'hC0A8_02C8, LOCAL_IP,        16'd7,     ECHO_PORT, 8'd32,  8'd2,  1'b0},
    '{32'h0A01_0203, LOCAL_IP,        ECHO_PORT, 16'd0,     8'd64,  8'd25, 1'b0},
    '{32'hC0A8_0101, LOCAL_IP,        16'd65535, ECHO_PORT, 8'd2,   8'd33, 1'b1},
    '{32'hC0A8_0163, 32'hC0A8_01FF,   16'd1111,  ECHO_PORT, 8'd64,  8'd6,  1'b0}
};

function automatic logic [15:0] udp_length(input frame_case_t fc);
    return 16'(UDP_HDR_BYTES) + 16'(fc.payload_len);
endfunction

// Reply swaps both ends and answers from the local address
function automatic udp_hdr_t expected_reply(input frame_case_t fc);
    udp_hdr_t r;
    r.src_ip   = LOCAL_IP;
    r.dst_ip   = fc.src_ip;
    r.src_port = fc.dst_port;
    r.dst_port = fc.src_port;
    r.length   = udp_length(fc);
    r.ttl      = REPLY_TTL;
    r.checksum = 16'd0;
    return r;
endfunction

function automatic int total_beats();
    int sum;
    sum = 0;
    for (int k = 0; k < NUM_CASES; k++) begin
        sum += FRAME_CASES[k].payload_len;
    end
    return sum;
endfunction

`endif

// ==== tb/udp_echo_tb.sv ====
/* UDP echo engine testbench */

`timescale 1ns/100ps

module udp_echo_tb
    import udp_echo_pkg::*;
;

    localparam int CLK_HALF_NS  = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PASSES   = 2;
    localparam int DRAIN_LIMIT  = 500;
    localparam int QUIET_CYCLES = 20;

    logic          clk_125mhz = 1'b0;
    logic          rst_125mhz;
    udp_hdr_t      rx_hdr;
    logic          rx_hdr_valid;
    logic          rx_hdr_ready;
    payload_beat_t rx_payload;
    logic          rx_payload_valid;
    logic          rx_payload_ready;
    udp_hdr_t      tx_hdr;
    logic          tx_hdr_valid;
    logic          tx_hdr_ready;
    payload_beat_t tx_payload;
    logic          tx_payload_valid;
    logic          tx_payload_ready;
    logic [7:0]    led;

    logic          bp_enable;
    udp_hdr_t      exp_hdr_q[$];
    payload_beat_t exp_beat_q[$];

    `include "udp_echo_cases.svh"

    udp_echo_top uut (.*);

    always #(CLK_HALF_NS) clk_125mhz = ~clk_125mhz;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        assert (got === expected) else begin
            abort_run($sformatf("FAILED at %0.1f ns: %s is 0x%0h, expected 0x%0h",
                                $realtime, name, got, expected));
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_header(input udp_hdr_t hdr);
        rx_hdr       = hdr;
        rx_hdr_valid = 1'b1;
        #1;
        while (!rx_hdr_ready) begin
            @(negedge clk_125mhz);
            #1;
        end
        @(negedge clk_125mhz);
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input payload_beat_t beat);
        rx_payload       = beat;
        rx_payload_valid = 1'b1;
        #1;
        while (!rx_payload_ready) begin
            @(negedge clk_125mhz);
            #1;
        end
        @(negedge clk_125mhz);
    endtask

    // Random stalls on both transmit ports in the second pass
    always @(negedge clk_125mhz) begin
        if (bp_enable) begin
            tx_hdr_ready     = ($urandom % 2) != 0;
            tx_payload_ready = ($urandom % 2) != 0;
        end else begin
            tx_hdr_ready     = 1'b1;
            tx_payload_ready = 1'b1;
        end
    end

    initial begin
        frame_case_t   fc;
        udp_hdr_t      hdr;
        payload_beat_t beat;
        logic          match;
        int            drain;
        void'($urandom(24));
        rst_125mhz       = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        bp_enable        = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_125mhz);
            compare_value("tx_hdr_valid", tx_hdr_valid, 0);
            compare_value("tx_payload_valid", tx_payload_valid, 0);
            compare_value("led", led, 0);
            compare_value("rx_hdr_ready", rx_hdr_ready, 0);
        end
        rst_125mhz = 1'b0;
        @(negedge clk_125mhz);
        compare_value("tx_hdr_valid", tx_hdr_valid, 0);
        compare_value("tx_payload_valid", tx_payload_valid, 0);
        compare_value("led", led, 0);

        for (int pass_idx = 0; pass_idx < NUM_PASSES; pass_idx++) begin
            bp_enable = (pass_idx == 1);
            for (int case_idx = 0; case_idx < NUM_CASES; case_idx++) begin
                fc           = FRAME_CASES[case_idx];
                match        = (fc.dst_port == ECHO_PORT);
                hdr.src_ip   = fc.src_ip;
                hdr.dst_ip   = fc.dst_ip;
                hdr.src_port = fc.src_port;
                hdr.dst_port = fc.dst_port;
                hdr.length   = udp_length(fc);
                hdr.ttl      = fc.ttl;
                hdr.checksum = 16'($urandom_range(16'hFFFF, 0));
                if (match) begin
                    exp_hdr_q.push_back(expected_reply(fc));
                end
                send_header(hdr);
                for (int i = 0; i < fc.payload_len; i++) begin
                    beat.data = 8'($urandom_range(255, 0));
                    beat.last = (i == fc.payload_len - 1);
                    beat.user = beat.last ? fc.last_user : 1'b0;
                    if (match) begin
                        exp_beat_q.push_back(beat);
                    end
                    send_beat(beat);
                end
                rx_payload_valid = 1'b0;
            end
        end

        drain = 0;
        while ((exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) && drain < DRAIN_LIMIT) begin
            @(negedge clk_125mhz);
            drain++;
        end
        // Extra cycles catch stray output from discarded frames
        repeat (QUIET_CYCLES) @(negedge clk_125mhz);
        assert (exp_hdr_q.size() == 0 && exp_beat_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run($sformatf("Run ended with %0d reply headers and %0d payload bytes never sent",
                                exp_hdr_q.size(), exp_beat_q.size()));
        end
    end

    // Header scoreboard, sampled while valid and ready are stable
    initial begin
        udp_hdr_t exp;
        forever begin
            @(negedge clk_125mhz);
            #1;
            if (tx_hdr_valid === 1'b1 && tx_hdr_ready) begin
                assert (exp_hdr_q.size() > 0) else begin
                    abort_run("A reply header was sent although no echoed frame was pending");
                end
                exp = exp_hdr_q.pop_front();
                compare_value("tx_hdr.src_ip", tx_hdr.src_ip, exp.src_ip);
                compare_value("tx_hdr.dst_ip", tx_hdr.dst_ip, exp.dst_ip);
                compare_value("tx_hdr.src_port", tx_hdr.src_port, exp.src_port);
                compare_value("tx_hdr.dst_port", tx_hdr.dst_port, exp.dst_port);
                compare_value("tx_hdr.length", tx_hdr.length, exp.length);
                compare_value("tx_hdr.ttl", tx_hdr.ttl, exp.ttl);
                compare_value("tx_hdr.checksum", tx_hdr.checksum, exp.checksum);
            end
        end
    end

    // Payload scoreboard with the LED check one cycle after each frame start
    initial begin
        payload_beat_t exp;
        logic          frame_start;
        logic          led_pending;
        logic [7:0]    led_exp;
        frame_start = 1'b1;
        led_pending = 1'b0;
        led_exp     = 8'd0;
        forever begin
            @(negedge clk_125mhz);
            #1;
            if (led_pending) begin
                compare_value("led", led, led_exp);
                led_pending = 1'b0;
            end
            if (tx_payload_valid === 1'b1 && tx_payload_ready) begin
                assert (exp_beat_q.size() > 0) else begin
                    abort_run("A payload byte was sent although no echoed byte was pending");
                end
                exp = exp_beat_q.pop_front();
                compare_value("tx_payload.data", tx_payload.data, exp.data);
                compare_value("tx_payload.last", tx_payload.last, exp.last);
                compare_value("tx_payload.user", tx_payload.user, exp.user);
                if (frame_start) begin
                    led_pending = 1'b1;
                    led_exp     = exp.data;
                end
                frame_start = exp.last;
            end
        end
    end

    initial begin
        int watchdog_cycles;
        watchdog_cycles = total_beats() * 20 + 2000;
        #(watchdog_cycles * 2 * CLK_HALF_NS);
        abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                            watchdog_cycles));
    end

endmodule

// ==== all.f ====
+incdir+tb
rtl/udp_echo_pkg.sv
rtl/stream_fifo.sv
rtl/udp_port_filter.sv
rtl/payload_led_capture.sv
rtl/udp_echo_top.sv
tb/udp_echo_tb.sv
